//--- dma_pkg.sv
/*
 * shared constants and the CPU byte decode for the DMA subsystem
 * imported by the engine, the memory, the SD buffer and the top level
 */
`default_nettype none

package dma_pkg;

	localparam int ADDR_W      = 21;    // DRAM word address
	localparam int MEM_DEPTH_W = 10;    // address bits backed by the on-chip memory
	localparam int REG_NUM     = 8;     // CPU-writable registers

	// one-hot write strobe positions
	localparam int REG_SADDRL = 0;
	localparam int REG_SADDRH = 1;
	localparam int REG_SADDRX = 2;
	localparam int REG_DADDRL = 3;
	localparam int REG_DADDRH = 4;
	localparam int REG_DADDRX = 5;
	localparam int REG_LEN    = 6;
	localparam int REG_CTRL   = 7;     // writing here launches a burst

	localparam logic [2:0] DEV_RAM = 3'b001;
	localparam logic [2:0] DEV_SD  = 3'b010;

	// SD byte queues, depth equals the credit count
	localparam int SD_DEPTH = 4;
	localparam int SD_PTR_W = $clog2(SD_DEPTH);
	localparam int SD_CNT_W = $clog2(SD_DEPTH + 1);

	// CPU data byte, raw for addresses and length, decoded for the control write
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic       wnr;       // 1 - RAM to device
			logic       zwait;     // stall the CPU while busy
			logic [2:0] spare;
			logic [2:0] device;
		} ctrl;
	} dma_ctrl_u;

endpackage

`default_nettype wire

//--- dma_engine.sv
/*
 * DMA engine: CPU programmed register file plus a read/write phase machine
 * moving 16-bit words between DRAM and DRAM or the SD byte channel
 */
`timescale 1ns/1ps
`default_nettype none

module dma_engine
	import dma_pkg::*;
(
	input  wire                 clk,
	input  wire                 rst_n,

	input  wire [REG_NUM-1:0]   reg_wr,
	input  wire [7:0]           reg_data,
	output logic                dma_act,
	output logic                dma_wait,

	output logic [ADDR_W-1:0]   dram_addr,
	input  wire  [15:0]         dram_rddata,
	output logic [15:0]         dram_wrdata,
	output logic                dram_req,
	output logic                dram_rnw,
	input  wire                 dram_next,

	input  wire  [7:0]          sd_rddata,
	output logic [7:0]          sd_wrdata,
	output logic                sd_req,
	output logic                sd_rnw,
	input  wire                 sd_stb
);

	dma_ctrl_u          cpu;
	logic [REG_NUM-1:0] wr;
	logic               launch;

	logic [ADDR_W-1:0]  s_addr;
	logic [ADDR_W-1:0]  d_addr;
	logic [7:0]         b_len;
	logic [8:0]         ctr;       // top bit set means idle
	logic [2:0]         device;
	logic               dma_wnr;
	logic               dma_zwait;
	logic               phase;     // 0 - read, 1 - write
	logic               bsel;      // 0 - low byte, 1 - high byte
	logic [15:0]        data;

	logic dv_ram;
	logic dv_sd;
	logic state_mem;
	logic state_dev;
	logic mem_done;
	logic sd_done;
	logic phase_end;
	logic cyc_end;

	assign cpu.raw = reg_data;
	assign wr      = reg_wr & {REG_NUM{~dma_act}};    // registers locked during a burst
	assign launch  = wr[REG_CTRL];

	assign dma_act  = ~ctr[8];
	assign dma_wait = dma_act & dma_zwait;

	assign dv_ram = device == DEV_RAM;
	assign dv_sd  = device == DEV_SD;

	// phase table
	//  wnr  phase  RAM  DEV
	//   0     0     0    1     device read
	//   0     1     1    0     RAM write
	//   1     0     1    0     RAM read
	//   1     1     0    1     device write
	// RAM to RAM uses memory in both phases
	assign state_mem = dv_ram | (dma_wnr ^ phase);
	assign state_dev = ~dv_ram & (dma_wnr ^ ~phase);

	assign dram_addr   = phase ? d_addr : s_addr;
	assign dram_wrdata = data;
	assign dram_req    = dma_act & state_mem;
	assign dram_rnw    = ~phase;

	assign sd_wrdata = bsel ? data[15:8] : data[7:0];    // low byte goes first
	assign sd_req    = dma_act & state_dev & dv_sd;
	assign sd_rnw    = ~phase;

	assign mem_done  = dram_req & dram_next;
	assign sd_done   = sd_req & sd_stb;
	assign phase_end = mem_done | (sd_done & bsel);    // SD phase ends on the second byte
	assign cyc_end   = phase & phase_end;

	// read data latch
	always_ff @(posedge clk)
	begin
		if (~phase & mem_done)
			data <= dram_rddata;
		else if (~phase & sd_done)
		begin
			if (bsel)
				data[15:8] <= sd_rddata;
			else
				data[7:0] <= sd_rddata;
		end
	end

	// burst control and phase sequencing
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			device    <= '0;
			dma_wnr   <= 1'b0;
			dma_zwait <= 1'b0;
			phase     <= 1'b0;
			bsel      <= 1'b0;
		end
		else if (launch)
		begin
			device    <= cpu.ctrl.device;
			dma_wnr   <= cpu.ctrl.wnr;
			dma_zwait <= cpu.ctrl.zwait;
			phase     <= 1'b0;
			bsel      <= 1'b0;
		end
		else
		begin
			if (phase_end)
				phase <= ~phase;
			if (sd_done)
				bsel <= ~bsel;
		end
	end

	// word counter, N loaded means N+1 words
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			ctr <= 9'h100;    // idle out of reset
		else if (launch)
			ctr <= {1'b0, b_len};
		else if (cyc_end)
			ctr <= ctr - 9'd1;
	end

	always_ff @(posedge clk)
	begin
		if (wr[REG_LEN])
			b_len <= cpu.raw;
	end

	// byte addresses from the CPU, word addresses inside
	always_ff @(posedge clk)
	begin
		if (wr[REG_SADDRL])
			s_addr[6:0] <= cpu.raw[7:1];
		if (wr[REG_SADDRH])
			s_addr[12:7] <= cpu.raw[5:0];
		if (wr[REG_SADDRX])
			s_addr[20:13] <= cpu.raw;

		if (wr[REG_DADDRL])
			d_addr[6:0] <= cpu.raw[7:1];
		if (wr[REG_DADDRH])
			d_addr[12:7] <= cpu.raw[5:0];
		if (wr[REG_DADDRX])
			d_addr[20:13] <= cpu.raw;

		if (mem_done & ~phase)
			s_addr <= s_addr + ADDR_W'(1);    // next source word
		if (mem_done & phase)
			d_addr <= d_addr + ADDR_W'(1);
	end

endmodule

`default_nettype wire

//--- dram_port.sv
/*
 * on-chip word memory standing in for DRAM
 * host port has fixed priority, DMA gets the free cycles
 */
`timescale 1ns/1ps
`default_nettype none

module dram_port
	import dma_pkg::*;
(
	input  wire                    clk,
	input  wire                    rst_n,

	// DMA side
	input  wire  [ADDR_W-1:0]      dram_addr,
	output logic [15:0]            dram_rddata,
	input  wire  [15:0]            dram_wrdata,
	input  wire                    dram_req,
	input  wire                    dram_rnw,
	output logic                   dram_next,

	// host side
	input  wire  [MEM_DEPTH_W-1:0] host_addr,
	input  wire  [15:0]            host_wdata,
	input  wire                    host_we,
	input  wire                    host_re,
	output logic [15:0]            host_rdata,
	output logic                   host_rvalid
);

	logic [15:0]            mem [0:(2**MEM_DEPTH_W)-1];
	logic [MEM_DEPTH_W-1:0] dma_idx;
	logic                   host_idle;

	assign dma_idx   = dram_addr[MEM_DEPTH_W-1:0];    // upper bits alias
	assign host_idle = ~host_we & ~host_re;

	// grant completes the DMA access in the same cycle
	assign dram_next   = dram_req & host_idle;
	assign dram_rddata = mem[dma_idx];

	always_ff @(posedge clk)
	begin
		if (host_we)
			mem[host_addr] <= host_wdata;
		else if (dram_next & ~dram_rnw)
			mem[dma_idx] <= dram_wrdata;
	end

	always_ff @(posedge clk)
	begin
		if (host_re)
			host_rdata <= mem[host_addr];
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			host_rvalid <= 1'b0;
		else
			host_rvalid <= host_re;    // data one cycle after the request
	end

endmodule

`default_nettype wire

//--- sd_buffer.sv
/*
 * SD side byte buffer between the engine strobe interface and the
 * credit based tx and rx byte links, one small queue per direction
 */
`timescale 1ns/1ps
`default_nettype none

module sd_buffer
	import dma_pkg::*;
(
	input  wire        clk,
	input  wire        rst_n,

	// engine side
	input  wire        sd_req,
	input  wire        sd_rnw,
	input  wire  [7:0] sd_wrdata,
	output logic [7:0] sd_rddata,
	output logic       sd_stb,

	// outgoing link
	output logic       sd_tx_valid,
	output logic [7:0] sd_tx_data,
	input  wire        sd_tx_credit,

	// incoming link
	input  wire        sd_rx_valid,
	input  wire  [7:0] sd_rx_data,
	output logic       sd_rx_credit
);

	logic [7:0]          tx_q [0:SD_DEPTH-1];
	logic [SD_PTR_W-1:0] tx_wp;
	logic [SD_PTR_W-1:0] tx_rp;
	logic [SD_CNT_W-1:0] tx_cnt;
	logic [SD_CNT_W-1:0] tx_crd;    // credits held for the far side
	logic                tx_push;
	logic                tx_pop;
	logic                tx_full;

	logic [7:0]          rx_q [0:SD_DEPTH-1];
	logic [SD_PTR_W-1:0] rx_wp;
	logic [SD_PTR_W-1:0] rx_rp;
	logic [SD_CNT_W-1:0] rx_cnt;
	logic                rx_pop;
	logic                rx_empty;

	assign tx_full  = tx_cnt == SD_CNT_W'(SD_DEPTH);
	assign rx_empty = rx_cnt == '0;

	assign sd_stb    = sd_req & (sd_rnw ? ~rx_empty : ~tx_full);
	assign sd_rddata = rx_q[rx_rp];

	assign tx_push = sd_stb & ~sd_rnw;
	assign tx_pop  = (tx_cnt != '0) & (tx_crd != '0);    // send only with a credit
	assign rx_pop  = sd_stb & sd_rnw;

	// tx queue payload
	always_ff @(posedge clk)
	begin
		if (tx_push)
			tx_q[tx_wp] <= sd_wrdata;
		if (tx_pop)
			sd_tx_data <= tx_q[tx_rp];
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			tx_wp       <= '0;
			tx_rp       <= '0;
			tx_cnt      <= '0;
			tx_crd      <= SD_CNT_W'(SD_DEPTH);
			sd_tx_valid <= 1'b0;
		end
		else
		begin
			if (tx_push)
				tx_wp <= tx_wp + 1'b1;
			if (tx_pop)
				tx_rp <= tx_rp + 1'b1;
			tx_cnt      <= tx_cnt + SD_CNT_W'(tx_push) - SD_CNT_W'(tx_pop);
			tx_crd      <= tx_crd + SD_CNT_W'(sd_tx_credit) - SD_CNT_W'(tx_pop);
			sd_tx_valid <= tx_pop;
		end
	end

	// rx queue never overflows while the sender keeps to its credits
	always_ff @(posedge clk)
	begin
		if (sd_rx_valid)
			rx_q[rx_wp] <= sd_rx_data;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rx_wp        <= '0;
			rx_rp        <= '0;
			rx_cnt       <= '0;
			sd_rx_credit <= 1'b0;
		end
		else
		begin
			if (sd_rx_valid)
				rx_wp <= rx_wp + 1'b1;
			if (rx_pop)
				rx_rp <= rx_rp + 1'b1;
			rx_cnt       <= rx_cnt + SD_CNT_W'(sd_rx_valid) - SD_CNT_W'(rx_pop);
			sd_rx_credit <= rx_pop;    // one credit back per consumed byte
		end
	end

endmodule

`default_nettype wire

//--- dma_subsys.sv
/*
 * DMA subsystem top: engine, on-chip word memory and SD byte buffer
 */
`timescale 1ns/1ps
`default_nettype none

module dma_subsys
	import dma_pkg::*;
(
	input  wire                    clk,
	input  wire                    rst_n,

	input  wire  [REG_NUM-1:0]     reg_wr,
	input  wire  [7:0]             reg_data,
	output logic                   dma_act,
	output logic                   dma_wait,

	input  wire  [MEM_DEPTH_W-1:0] host_addr,
	input  wire  [15:0]            host_wdata,
	input  wire                    host_we,
	input  wire                    host_re,
	output logic [15:0]            host_rdata,
	output logic                   host_rvalid,

	output logic                   sd_tx_valid,
	output logic [7:0]             sd_tx_data,
	input  wire                    sd_tx_credit,
	input  wire                    sd_rx_valid,
	input  wire  [7:0]             sd_rx_data,
	output logic                   sd_rx_credit
);

	logic [ADDR_W-1:0] dram_addr;
	logic [15:0]       dram_rddata;
	logic [15:0]       dram_wrdata;
	logic              dram_req;
	logic              dram_rnw;
	logic              dram_next;

	logic [7:0]        sd_rddata;
	logic [7:0]        sd_wrdata;
	logic              sd_req;
	logic              sd_rnw;
	logic              sd_stb;

	dma_engine engine0 (
		.clk, .rst_n, .reg_wr, .reg_data, .dma_act, .dma_wait,
		.dram_addr, .dram_rddata, .dram_wrdata, .dram_req, .dram_rnw, .dram_next,
		.sd_rddata, .sd_wrdata, .sd_req, .sd_rnw, .sd_stb
	);

	dram_port mem0 (
		.clk, .rst_n,
		.dram_addr, .dram_rddata, .dram_wrdata, .dram_req, .dram_rnw, .dram_next,
		.host_addr, .host_wdata, .host_we, .host_re, .host_rdata, .host_rvalid
	);

	sd_buffer sd0 (
		.clk, .rst_n,
		.sd_req, .sd_rnw, .sd_wrdata, .sd_rddata, .sd_stb,
		.sd_tx_valid, .sd_tx_data, .sd_tx_credit,
		.sd_rx_valid, .sd_rx_data, .sd_rx_credit
	);

endmodule

`default_nettype wire

//--- tb_dma.sv
/*
 * testbench for the DMA subsystem
 * programs bursts over the CPU registers, models both SD credit links
 * and checks memory and byte streams against a reference model
 */
`timescale 1ns/1ps
`default_nettype none

module tb_dma
	import dma_pkg::*;
();

	localparam int LIMIT = 4000;    // cycles allowed per wait

	logic               clk;
	logic               rst_n;
	logic [REG_NUM-1:0] reg_wr;
	logic [7:0]         reg_data;
	logic               dma_act;
	logic               dma_wait;
	logic [MEM_DEPTH_W-1:0] host_addr;
	logic [15:0]        host_wdata;
	logic               host_we;
	logic               host_re;
	logic [15:0]        host_rdata;
	logic               host_rvalid;
	logic               sd_tx_valid;
	logic [7:0]         sd_tx_data;
	logic               sd_tx_credit;
	logic               sd_rx_valid;
	logic [7:0]         sd_rx_data;
	logic               sd_rx_credit;

	int          seed = 32'hf179a082;
	string       test_name = "init";
	logic [15:0] shadow [0:(2**MEM_DEPTH_W)-1];    // what the host port wrote
	logic [7:0]  rx_feed [$];
	logic [7:0]  rx_log [$];
	int          rx_crd = SD_DEPTH;
	int          rx_credit_pulses = 0;
	int          tx_seen = 0;       // written by the monitor only
	int          tx_returned = 0;
	int          tx_base = 0;
	int          tx_src = 0;
	int          tx_total = 0;
	logic        stall_credits = 1'b0;
	logic        traffic = 1'b0;
	logic        exp_zwait = 1'b0;
	int          check_errs = 0;
	int          stream_errs = 0;
	int          timeout_errs = 0;
	int          mon_k;
	logic [15:0] mon_w;
	logic [7:0]  mon_b;

	dma_subsys dut0 (
		.clk, .rst_n, .reg_wr, .reg_data, .dma_act, .dma_wait,
		.host_addr, .host_wdata, .host_we, .host_re, .host_rdata, .host_rvalid,
		.sd_tx_valid, .sd_tx_data, .sd_tx_credit,
		.sd_rx_valid, .sd_rx_data, .sd_rx_credit
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// expected word i of a burst from the source memory image or the fed byte stream
	function automatic logic [15:0] ref_word(input logic from_sd, input int src, input int i);
		logic [15:0] w;
		if (from_sd)
			w = {rx_log[2*i+1], rx_log[2*i]};    // low byte arrives first
		else
			w = shadow[(src + i) % (2**MEM_DEPTH_W)];
		return w;
	endfunction

	task automatic finish_run();
		$display("errors: %0d check, %0d stream, %0d timeout",
			check_errs, stream_errs, timeout_errs);
		if (check_errs == 0 && stream_errs == 0 && timeout_errs == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	endtask

	task automatic timed_out(input string what);
		$display("ERROR %s: no response within %0d cycles while waiting for %s",
			test_name, LIMIT, what);
		timeout_errs++;
		finish_run();
	endtask

	// advance to the next falling edge and drive both SD link far ends and host traffic
	task automatic next_cycle();
		@(negedge clk);
		if (!stall_credits && tx_seen > tx_returned && ($random(seed) & 3) == 0)
		begin
			sd_tx_credit = 1'b1;
			tx_returned++;
		end
		else
			sd_tx_credit = 1'b0;
		if (sd_rx_credit)
		begin
			rx_crd++;
			rx_credit_pulses++;
		end
		if (rx_feed.size() > 0 && rx_crd > 0 && ($random(seed) & 1) == 1)
		begin
			sd_rx_valid = 1'b1;
			sd_rx_data  = rx_feed.pop_front();
			rx_crd--;    // sender never exceeds its credits
		end
		else
			sd_rx_valid = 1'b0;
		if (traffic)
		begin
			host_addr  = 10'(960 + ($random(seed) & 63));    // above all test regions
			host_wdata = 16'($random(seed));
			host_we    = ($random(seed) & 3) == 0;
			host_re    = !host_we && ($random(seed) & 1) == 1;
			if (host_we)
				shadow[host_addr] = host_wdata;
		end
	endtask

	task automatic check_word(input string what, input logic [15:0] exp, input logic [15:0] act);
		assert (act === exp) else
		begin
			$display("CHECK FAILED %s: %s expected %h actual %h", test_name, what, exp, act);
			check_errs++;
		end
	endtask

	task automatic check_count(input string what, input int exp, input int act);
		assert (act == exp) else
		begin
			$display("CHECK FAILED %s: %s expected %0d actual %0d", test_name, what, exp, act);
			check_errs++;
		end
	endtask

	task automatic host_write(input int addr, input logic [15:0] data);
		next_cycle();
		host_addr    = 10'(addr);
		host_wdata   = data;
		host_we      = 1'b1;
		shadow[addr] = data;
		next_cycle();
		host_we = 1'b0;
	endtask

	task automatic host_read(input int addr, output logic [15:0] data);
		int n;
		next_cycle();
		host_addr = 10'(addr);
		host_re   = 1'b1;
		next_cycle();
		host_re = 1'b0;
		for (n = 0; n < LIMIT && host_rvalid !== 1'b1; n++)
			next_cycle();
		if (host_rvalid !== 1'b1)
			timed_out("host read data");
		else
			data = host_rdata;
	endtask

	task automatic reg_write(input int idx, input logic [7:0] val);
		next_cycle();
		reg_wr   = REG_NUM'(1) << idx;
		reg_data = val;
		next_cycle();
		reg_wr = '0;
	endtask

	// word addresses become byte addresses on the CPU bus and the control byte goes last
	task automatic program_burst(input int src, input int dst, input int n,
			input logic wnr, input logic zwait, input logic [2:0] dev);
		dma_ctrl_u c;
		c.raw          = '0;
		c.ctrl.wnr     = wnr;
		c.ctrl.zwait   = zwait;
		c.ctrl.device  = dev;
		reg_write(REG_SADDRL, {src[6:0], 1'b0});
		reg_write(REG_SADDRH, {2'b00, src[12:7]});
		reg_write(REG_SADDRX, src[20:13]);
		reg_write(REG_DADDRL, {dst[6:0], 1'b0});
		reg_write(REG_DADDRH, {2'b00, dst[12:7]});
		reg_write(REG_DADDRX, dst[20:13]);
		reg_write(REG_LEN, 8'(n));
		reg_write(REG_CTRL, c.raw);
	endtask

	task automatic wait_idle(input logic traffic_on);
		int n;
		traffic = traffic_on;
		for (n = 0; n < LIMIT && dma_act; n++)
			next_cycle();
		traffic = 1'b0;
		if (dma_act)
			timed_out("the end of the burst");
		else
		begin
			next_cycle();    // let the last host access land
			host_we = 1'b0;
			host_re = 1'b0;
		end
	endtask

	task automatic wait_tx(input int total);
		int n;
		for (n = 0; n < LIMIT && tx_seen - tx_base < total; n++)
			next_cycle();
		if (tx_seen - tx_base < total)
			timed_out("bytes on sd_tx");
		else
		begin
			for (n = 0; n < 20; n++)
				next_cycle();    // room for a stray extra byte to show up
			check_count("sd_tx byte count", total, tx_seen - tx_base);
		end
	endtask

	task automatic wait_credits_back();
		int n;
		for (n = 0; n < LIMIT && tx_returned != tx_seen; n++)
			next_cycle();
		if (tx_returned != tx_seen)
			timed_out("tx credit returns");
	endtask

	task automatic fill_words(input int base, input int words);
		int i;
		for (i = 0; i < words; i++)
			host_write(base + i, 16'($random(seed)));
	endtask

	task automatic compare_words(input logic from_sd, input int src, input int dst, input int words);
		int i;
		logic [15:0] got;
		for (i = 0; i < words; i++)
		begin
			host_read(dst + i, got);
			check_word($sformatf("word %0d", i), ref_word(from_sd, src, i), got);
		end
	endtask

	task automatic start_tx_stream(input int src, input int words);
		tx_src   = src;
		tx_total = 2 * words;
		tx_base  = tx_seen;
	endtask

	// compare process for the outgoing byte stream, credit use and dma_wait
	always @(posedge clk)
	begin
		if (rst_n)
		begin
			assert (dma_wait == (dma_act && exp_zwait)) else
			begin
				$display("CHECK FAILED %s: dma_wait expected %b actual %b",
					test_name, dma_act && exp_zwait, dma_wait);
				stream_errs++;
			end
			if (sd_tx_valid)
			begin
				mon_k = tx_seen - tx_base;
				assert (tx_seen + 1 - tx_returned <= SD_DEPTH) else
				begin
					$display("ERROR %s: byte sent on sd_tx with no credit left", test_name);
					stream_errs++;
				end
				assert (mon_k < tx_total) else
				begin
					$display("ERROR %s: byte %0d on sd_tx beyond the %0d expected",
						test_name, mon_k, tx_total);
					stream_errs++;
				end
				if (mon_k < tx_total)
				begin
					mon_w = ref_word(1'b0, tx_src, mon_k / 2);
					mon_b = mon_k[0] ? mon_w[15:8] : mon_w[7:0];
					assert (sd_tx_data === mon_b) else
					begin
						$display("CHECK FAILED %s: tx byte %0d expected %h actual %h",
							test_name, mon_k, mon_b, sd_tx_data);
						stream_errs++;
					end
				end
				tx_seen++;
			end
		end
	end

	initial
	begin
		int i;
		int pulses0;
		logic [7:0] b;

		rst_n        = 1'b0;
		reg_wr       = '0;
		reg_data     = '0;
		host_addr    = '0;
		host_wdata   = '0;
		host_we      = 1'b0;
		host_re      = 1'b0;
		sd_tx_credit = 1'b0;
		sd_rx_valid  = 1'b0;
		sd_rx_data   = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		test_name = "reset";
		next_cycle();
		check_count("dma_act", 0, int'(dma_act));
		check_count("sd_tx_valid", 0, int'(sd_tx_valid));
		check_count("host_rvalid", 0, int'(host_rvalid));

		// plain copy with zwait set so dma_wait tracks dma_act
		test_name = "ram_copy";
		fill_words(32, 12);
		exp_zwait = 1'b1;
		program_burst(32, 300, 11, 1'b0, 1'b1, DEV_RAM);
		check_count("dma_act after launch", 1, int'(dma_act));
		wait_idle(1'b0);
		exp_zwait = 1'b0;
		compare_words(1'b0, 32, 300, 12);

		test_name = "ram_to_sd";
		fill_words(100, 8);
		start_tx_stream(100, 8);
		program_burst(100, 0, 7, 1'b1, 1'b0, DEV_SD);
		wait_idle(1'b0);
		wait_tx(16);

		test_name = "sd_to_ram";
		rx_log.delete();
		for (i = 0; i < 20; i++)
		begin
			b = 8'($random(seed));
			rx_log.push_back(b);
			rx_feed.push_back(b);
		end
		pulses0 = rx_credit_pulses;
		program_burst(0, 400, 9, 1'b0, 1'b0, DEV_SD);
		wait_idle(1'b0);
		compare_words(1'b1, 0, 400, 10);
		check_count("sd_rx_credit pulses", 20, rx_credit_pulses - pulses0);

		// credits held back first and released later under host traffic
		test_name = "backpressure";
		fill_words(500, 16);
		wait_credits_back();
		start_tx_stream(500, 16);
		stall_credits = 1'b1;
		program_burst(500, 0, 15, 1'b1, 1'b0, DEV_SD);
		for (i = 0; i < 60; i++)
			next_cycle();
		check_count("dma_act with credits stalled", 1, int'(dma_act));
		check_count("bytes sent on stalled credits", SD_DEPTH, tx_seen - tx_base);
		stall_credits = 1'b0;
		wait_idle(1'b1);
		wait_tx(32);

		test_name = "locked_regs";
		fill_words(600, 21);
		program_burst(600, 700, 20, 1'b0, 1'b0, DEV_RAM);
		program_burst(650, 800, 3, 1'b1, 1'b1, DEV_SD);    // must be ignored
		check_count("dma_act after register writes", 1, int'(dma_act));
		wait_idle(1'b1);
		compare_words(1'b0, 600, 700, 21);

		finish_run();
	end

endmodule

`default_nettype wire

//--- compile.f
dma_pkg.sv
dma_engine.sv
dram_port.sv
sd_buffer.sv
dma_subsys.sv
tb_dma.sv

//--- run.sh
#!/usr/bin/env bash
# build the DMA subsystem testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_dma -f compile.f -o tb_dma
out=$(./obj_dir/tb_dma)
echo "$out"
if echo "$out" | grep -q "^Simulation passed$"; then
	exit 0
fi
exit 1
